//--- verilog/synctimer_pkg.sv
`default_nettype none

package synctimer_pkg;

    // --------------------
    // time and offsets
    // --------------------
    localparam int unsigned TIME_WIDTH   = 64;  // carried as 8 bytes
    localparam int unsigned OFFSET_WIDTH = 24;

    typedef logic [TIME_WIDTH-1:0]   time_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;
    typedef logic [7:0]              byte_t;    // payload stream unit

    // one round trip, shared by every slave filter
    typedef struct packed {
        offset_t response_time;  // cmd start to response start
        offset_t packet_time;    // response start to response finish
    } measure_t;

    // --------------------
    // command codes
    // --------------------
    typedef enum logic [7:0] {
        cmd_nop           = 8'h00,  // measurement only
        cmd_correct       = 8'h01,
        cmd_correct_renew = 8'h03   // first correction, slaves reload
    } cmd_code_t;

    // --------------------
    // payload layout
    // --------------------
    // code byte, then time, then one offset word per slave
    localparam int unsigned CODE_BYTES   = 1;
    localparam int unsigned TIME_BYTES   = TIME_WIDTH / 8;
    localparam int unsigned OFFSET_BYTES = 4;  // upper byte always zero
    localparam int unsigned HEADER_BYTES = CODE_BYTES + TIME_BYTES;

endpackage

`default_nettype wire

//--- verilog/synctimer_timer.sv
`timescale 1ns/100ps
`default_nettype none

module synctimer_timer #(
    parameter int unsigned NUMERATOR   = 10,
    parameter int unsigned DENOMINATOR = 3
) (
    input  var logic                 clk,
    input  var logic                 reset,
    input  var synctimer_pkg::time_t set_time,
    input  var logic                 set_valid,
    output synctimer_pkg::time_t     current_time
);
    import synctimer_pkg::*;

    // clock period is NUMERATOR/DENOMINATOR time units
    localparam int unsigned STEP_INT   = NUMERATOR / DENOMINATOR;
    localparam int unsigned STEP_FRAC  = NUMERATOR % DENOMINATOR;
    localparam int unsigned FRAC_WIDTH = $clog2(DENOMINATOR) + 1;

    logic [FRAC_WIDTH-1:0] frac_acc;   // always below DENOMINATOR
    logic [FRAC_WIDTH-1:0] frac_sum;
    logic                  carry;
    time_t                 step;

    // --------------------
    // step calculation
    // --------------------
    always_comb begin
        frac_sum = frac_acc + FRAC_WIDTH'(STEP_FRAC);
        carry    = (frac_sum >= FRAC_WIDTH'(DENOMINATOR));
        step     = time_t'(STEP_INT) + time_t'(carry);  // integer part plus carry
    end

    // --------------------
    // time register
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            current_time <= '0;
            frac_acc     <= '0;
        end else if (set_valid) begin
            current_time <= set_time;  // load restarts the fraction
            frac_acc     <= '0;
        end else begin
            current_time <= current_time + step;
            if (carry) begin
                frac_acc <= frac_sum - FRAC_WIDTH'(DENOMINATOR);
            end else begin
                frac_acc <= frac_sum;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/synctimer_response_rx.sv
`timescale 1ns/100ps
`default_nettype none

module synctimer_response_rx #(
    parameter int unsigned MAX_NODES = 3
) (
    input  var logic                    clk,
    input  var logic                    reset,
    input  var synctimer_pkg::time_t    current_time,
    input  var logic                    cmd_start,
    input  var logic                    res_start,
    input  var logic                    res_finish,
    input  var logic                    res_enable,
    input  var logic                    res_payload_setup,
    input  var synctimer_pkg::byte_t    res_data,
    input  var logic                    res_valid,
    output synctimer_pkg::measure_t     meas,
    output synctimer_pkg::offset_t      slave_delay [0:MAX_NODES-2],
    output logic                        meas_valid
);
    import synctimer_pkg::*;

    localparam int unsigned MAX_SLAVES = MAX_NODES - 1;
    localparam int unsigned RES_LENGTH = HEADER_BYTES + OFFSET_BYTES * MAX_SLAVES;
    localparam int unsigned KEPT_BYTES = OFFSET_WIDTH / 8;  // rest of the word is dropped

    offset_t               tx_start_time;
    offset_t               rx_start_time;
    logic [RES_LENGTH-1:0] byte_flag;      // one-hot byte position

    // --------------------
    // round trip timestamps
    // --------------------
    always_ff @(posedge clk) begin
        if (cmd_start) begin
            tx_start_time <= offset_t'(current_time);
        end
        if (res_start) begin
            rx_start_time      <= offset_t'(current_time);
            meas.response_time <= offset_t'(current_time) - tx_start_time;
        end
        if (res_finish && res_enable) begin
            meas.packet_time <= offset_t'(current_time) - rx_start_time;
        end
    end

    // round end, filters start one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            meas_valid <= 1'b0;
        end else begin
            meas_valid <= res_finish && res_enable;
        end
    end

    // --------------------
    // response payload
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            byte_flag <= '0;
        end else if (res_payload_setup && res_enable) begin
            byte_flag <= RES_LENGTH'(1);  // arm byte 0
        end else if (res_valid) begin
            byte_flag <= byte_flag << 1;
        end
    end

    // scatter the delay words, lsb first
    always_ff @(posedge clk) begin
        if (res_valid) begin
            for (int n = 0; n < MAX_SLAVES; n++) begin
                for (int i = 0; i < KEPT_BYTES; i++) begin
                    if (byte_flag[HEADER_BYTES + OFFSET_BYTES * n + i]) begin
                        slave_delay[n][8*i +: 8] <= res_data;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/synctimer_offset_filter.sv
`timescale 1ns/100ps
`default_nettype none

module synctimer_offset_filter #(
    parameter int unsigned LPF_GAIN = 8
) (
    input  var logic                    clk,
    input  var logic                    reset,
    input  var synctimer_pkg::measure_t meas,
    input  var synctimer_pkg::offset_t  slave_delay,
    input  var logic                    meas_valid,
    output synctimer_pkg::offset_t      tx_offset
);
    import synctimer_pkg::*;

    // extra bit holds the doubled round trip before halving
    localparam int unsigned ACC_WIDTH = OFFSET_WIDTH + LPF_GAIN + 1;

    typedef logic [ACC_WIDTH-1:0] acc_t;

    logic [1:0] stage_valid;
    offset_t    delay;
    offset_t    packet_x2;    // travels with delay through stage 1
    offset_t    measured;
    acc_t       acc;
    logic       loaded;       // low until the first round lands

    // --------------------
    // stages 1 and 2
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= {stage_valid[0], meas_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (meas_valid) begin
            delay     <= meas.response_time - slave_delay;
            packet_x2 <= meas.packet_time << 1;
        end
        if (stage_valid[0]) begin
            measured <= delay + packet_x2;
        end
    end

    // --------------------
    // stage 3, low-pass
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            acc    <= '0;
            loaded <= 1'b0;
        end else if (stage_valid[1]) begin
            loaded <= 1'b1;
            if (loaded) begin
                acc <= acc - (acc >> LPF_GAIN) + acc_t'(measured);  // weight 1/2^N
            end else begin
                acc <= acc_t'(measured) << LPF_GAIN;  // start at the first sample
            end
        end
    end

    // scale back and halve the round trip
    assign tx_offset = offset_t'(acc >> (LPF_GAIN + 1));

endmodule

`default_nettype wire

//--- verilog/synctimer_cmd_tx.sv
`timescale 1ns/100ps
`default_nettype none

module synctimer_cmd_tx #(
    parameter int unsigned MAX_NODES = 3
) (
    input  var logic                   clk,
    input  var logic                   reset,
    input  var synctimer_pkg::time_t   current_time,
    input  var synctimer_pkg::offset_t tx_offset [0:MAX_NODES-2],
    input  var logic                   meas_valid,
    input  var logic                   cmd_start,
    input  var logic                   cmd_enable,
    output synctimer_pkg::byte_t       cmd_data,
    output logic                       cmd_valid,
    input  var logic                   cmd_ready
);
    import synctimer_pkg::*;

    localparam int unsigned MAX_SLAVES = MAX_NODES - 1;
    localparam int unsigned CMD_LENGTH = HEADER_BYTES + OFFSET_BYTES * MAX_SLAVES;

    cmd_code_t              code;
    byte_t [CMD_LENGTH-1:0] payload;       // byte 0 is on the bus
    byte_t [CMD_LENGTH-1:0] payload_init;

    // --------------------
    // command code
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            code <= cmd_nop;
        end else if (meas_valid) begin
            if (code == cmd_nop) begin
                code <= cmd_correct_renew;  // slaves take the first offset as is
            end else begin
                code <= cmd_correct;
            end
        end
    end

    // --------------------
    // payload build
    // --------------------
    always_comb begin
        payload_init    = '0;
        payload_init[0] = byte_t'(code);
        for (int i = 0; i < TIME_BYTES; i++) begin
            payload_init[CODE_BYTES + i] = current_time[8*i +: 8];  // lsb first
        end
        for (int n = 0; n < MAX_SLAVES; n++) begin
            for (int i = 0; i < OFFSET_BYTES; i++) begin
                payload_init[HEADER_BYTES + OFFSET_BYTES * n + i] =
                    byte_t'({8'h00, tx_offset[n]} >> (8 * i));
            end
        end
    end

    // --------------------
    // byte stream
    // --------------------
    always_ff @(posedge clk) begin
        if (cmd_start) begin
            payload <= payload_init;  // time sampled right here
        end else if (cmd_enable && cmd_ready) begin
            payload <= payload >> 8;  // next byte on accept
        end
    end

    assign cmd_data  = payload[0];
    assign cmd_valid = cmd_enable;  // link owns the framing

endmodule

`default_nettype wire

//--- verilog/synctimer_master.sv
`timescale 1ns/100ps
`default_nettype none

module synctimer_master #(
    parameter int unsigned NUMERATOR   = 10,
    parameter int unsigned DENOMINATOR = 3,
    parameter int unsigned MAX_NODES   = 3,   // master included
    parameter int unsigned LPF_GAIN    = 8
) (
    input  var logic                 clk,
    input  var logic                 reset,
    input  var synctimer_pkg::time_t set_time,
    input  var logic                 set_valid,
    output synctimer_pkg::time_t     current_time,
    input  var logic                 cmd_start,
    input  var logic                 cmd_enable,
    output synctimer_pkg::byte_t     cmd_data,
    output logic                     cmd_valid,
    input  var logic                 cmd_ready,
    input  var logic                 res_start,
    input  var logic                 res_finish,
    input  var logic                 res_enable,
    input  var logic                 res_payload_setup,
    input  var synctimer_pkg::byte_t res_data,
    input  var logic                 res_valid
);
    import synctimer_pkg::*;

    localparam int unsigned MAX_SLAVES = MAX_NODES - 1;

    measure_t meas;
    logic     meas_valid;
    offset_t  slave_delay [0:MAX_SLAVES-1];
    offset_t  tx_offset   [0:MAX_SLAVES-1];

    synctimer_timer #(
        .NUMERATOR   (NUMERATOR),
        .DENOMINATOR (DENOMINATOR)
    ) u_timer (
        .clk          (clk),
        .reset        (reset),
        .set_time     (set_time),
        .set_valid    (set_valid),
        .current_time (current_time)
    );

    synctimer_response_rx #(
        .MAX_NODES (MAX_NODES)
    ) u_response_rx (
        .clk               (clk),
        .reset             (reset),
        .current_time      (current_time),
        .cmd_start         (cmd_start),
        .res_start         (res_start),
        .res_finish        (res_finish),
        .res_enable        (res_enable),
        .res_payload_setup (res_payload_setup),
        .res_data          (res_data),
        .res_valid         (res_valid),
        .meas              (meas),
        .slave_delay       (slave_delay),
        .meas_valid        (meas_valid)
    );

    // one filter per slave
    for (genvar n = 0; n < MAX_SLAVES; n++) begin : g_filter
        synctimer_offset_filter #(
            .LPF_GAIN (LPF_GAIN)
        ) u_offset_filter (
            .clk         (clk),
            .reset       (reset),
            .meas        (meas),
            .slave_delay (slave_delay[n]),
            .meas_valid  (meas_valid),
            .tx_offset   (tx_offset[n])
        );
    end

    synctimer_cmd_tx #(
        .MAX_NODES (MAX_NODES)
    ) u_cmd_tx (
        .clk          (clk),
        .reset        (reset),
        .current_time (current_time),
        .tx_offset    (tx_offset),
        .meas_valid   (meas_valid),
        .cmd_start    (cmd_start),
        .cmd_enable   (cmd_enable),
        .cmd_data     (cmd_data),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;  // released on a rising edge
    end

endmodule

`default_nettype wire

//--- verification/synctimer_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module synctimer_asserts (
    input var logic                 clk,
    input var logic                 reset,
    input var logic                 cmd_valid,
    input var logic                 cmd_ready,
    input var synctimer_pkg::byte_t cmd_data,
    input var logic                 meas_valid
);
    // --------------------
    // command stream
    // --------------------
    a_no_valid_in_reset : assert property (@(posedge clk) reset |-> !cmd_valid)
        else $error("cmd_valid high during reset");

    // back-pressure holds the byte
    a_hold_data : assert property (@(posedge clk) disable iff (reset)
        (cmd_valid && !cmd_ready) |=> $stable(cmd_data))
        else $error("cmd_data changed while stalled");

    // round end is a single pulse
    a_meas_pulse : assert property (@(posedge clk) disable iff (reset)
        meas_valid |=> !meas_valid)
        else $error("meas_valid high on two cycles in a row");

endmodule

bind synctimer_master synctimer_asserts u_asserts (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_data   (cmd_data),
    .meas_valid (meas_valid)
);

`default_nettype wire

//--- verification/synctimer_tb.sv
`timescale 1ns/100ps
`default_nettype none

module synctimer_tb;
    import synctimer_pkg::*;

    localparam longint unsigned NUMERATOR   = 10;
    localparam longint unsigned DENOMINATOR = 3;
    localparam int LPF_GAIN   = 8;
    localparam int MAX_SLAVES = 2;
    localparam int CMD_LENGTH = 9 + 4 * MAX_SLAVES;
    localparam int ROUND_WAIT = 100;  // keeps response time above the slave delays

    // rough cycle budget per test
    localparam int RESET_CYCLES   = 16;
    localparam int START_CYCLES   = 20;
    localparam int LOAD_CYCLES    = 30;
    localparam int COMMAND_CYCLES = 80;
    localparam int ROUND_CYCLES   = ROUND_WAIT + CMD_LENGTH + 20;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + START_CYCLES + LOAD_CYCLES
                                  + 4 * COMMAND_CYCLES + 3 * ROUND_CYCLES + 200;

    logic    clk;
    logic    reset;
    time_t   set_time;
    logic    set_valid;
    time_t   current_time;
    logic    cmd_start;
    logic    cmd_enable;
    byte_t   cmd_data;
    logic    cmd_valid;
    logic    cmd_ready;
    logic    res_start;
    logic    res_finish;
    logic    res_enable;
    logic    res_payload_setup;
    byte_t   res_data;
    logic    res_valid;

    int               errors;
    int               cycle_count;
    logic [31:0]      lfsr_state;
    time_t            model_base;
    longint unsigned  model_k;
    time_t            cmd_time;       // model time seen at cmd_start
    byte_t            rx_bytes [0:CMD_LENGTH-1];
    logic [32:0]      model_acc [0:MAX_SLAVES-1];
    logic             model_loaded;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    synctimer_master uut (
        .clk               (clk),
        .reset             (reset),
        .set_time          (set_time),
        .set_valid         (set_valid),
        .current_time      (current_time),
        .cmd_start         (cmd_start),
        .cmd_enable        (cmd_enable),
        .cmd_data          (cmd_data),
        .cmd_valid         (cmd_valid),
        .cmd_ready         (cmd_ready),
        .res_start         (res_start),
        .res_finish        (res_finish),
        .res_enable        (res_enable),
        .res_payload_setup (res_payload_setup),
        .res_data          (res_data),
        .res_valid         (res_valid)
    );

    // --------------------
    // timer model
    // --------------------
    always @(posedge clk) begin
        if (reset) begin
            model_base <= '0;
            model_k    <= 0;
        end else if (set_valid) begin
            model_base <= set_time;
            model_k    <= 0;
        end else begin
            model_k <= model_k + 1;
        end
    end

    // k cycles after a load: base + floor(k * num / den)
    function automatic time_t model_time();
        return model_base + (model_k * NUMERATOR) / DENOMINATOR;
    endfunction

    // galois lfsr, one step per bit
    function automatic logic next_bit();
        logic lsb;
        lsb        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'hA300_0000;
        end
        return lsb;
    endfunction

    function automatic logic [63:0] draw_bits(input int count);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            v = {v[62:0], next_bit()};
        end
        return v;
    endfunction

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_time(input string name, input time_t got, input time_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_offset(input string name, input offset_t got, input offset_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_code(input string name, input cmd_code_t got, input cmd_code_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // --------------------
    // command collection
    // --------------------
    task automatic collect_command(input logic random_ready);
        int count;
        count = 0;
        @(posedge clk);
        cmd_start <= 1'b1;
        @(negedge clk);
        cmd_time = model_time();  // payload takes this time on the next edge
        @(posedge clk);
        cmd_start  <= 1'b0;
        cmd_enable <= 1'b1;
        cmd_ready  <= random_ready ? next_bit() : 1'b1;
        while (count < CMD_LENGTH) begin
            @(negedge clk);
            if (cmd_valid && cmd_ready) begin
                rx_bytes[count] = cmd_data;
                count++;
            end
            @(posedge clk);
            if (count < CMD_LENGTH) begin
                cmd_ready <= random_ready ? next_bit() : 1'b1;
            end else begin
                cmd_enable <= 1'b0;
                cmd_ready  <= 1'b0;
            end
        end
    endtask

    task automatic check_command(input cmd_code_t exp_code);
        time_t   got_time;
        offset_t got_off;
        int      base;
        check_code("cmd code", cmd_code_t'(rx_bytes[0]), exp_code);
        for (int i = 0; i < 8; i++) begin
            got_time[8*i +: 8] = rx_bytes[1 + i];
        end
        check_time("cmd time", got_time, cmd_time);
        for (int n = 0; n < MAX_SLAVES; n++) begin
            base    = 9 + 4 * n;
            got_off = {rx_bytes[base + 2], rx_bytes[base + 1], rx_bytes[base]};
            check_offset("cmd offset", got_off, offset_t'(model_acc[n] >> (LPF_GAIN + 1)));
            check_byte("cmd offset upper byte", rx_bytes[base + 3], 8'h00);
        end
    endtask

    // --------------------
    // response round
    // --------------------
    task automatic run_round(input logic enable);
        time_t   t_rs;
        time_t   t_rf;
        offset_t resp;
        offset_t packet;
        offset_t delay;
        offset_t measured;
        offset_t slave_delay [0:MAX_SLAVES-1];
        byte_t   bytes [0:CMD_LENGTH-1];
        for (int i = 0; i < 9; i++) begin
            bytes[i] = byte_t'(draw_bits(8));
        end
        for (int n = 0; n < MAX_SLAVES; n++) begin
            slave_delay[n]   = offset_t'(draw_bits(8));
            bytes[9 + 4 * n] = slave_delay[n][7:0];
            bytes[10 + 4 * n] = 8'h00;
            bytes[11 + 4 * n] = 8'h00;
            bytes[12 + 4 * n] = byte_t'(draw_bits(8));  // truncated by the receiver
        end
        repeat (ROUND_WAIT) @(posedge clk);
        res_start <= 1'b1;
        @(negedge clk);
        t_rs = model_time();
        @(posedge clk);
        res_start         <= 1'b0;
        res_enable        <= enable;
        res_payload_setup <= 1'b1;
        @(posedge clk);
        res_payload_setup <= 1'b0;
        for (int i = 0; i < CMD_LENGTH; i++) begin
            res_valid <= 1'b1;
            res_data  <= bytes[i];
            @(posedge clk);
        end
        res_valid  <= 1'b0;
        res_finish <= 1'b1;
        @(negedge clk);
        t_rf = model_time();
        @(posedge clk);
        res_finish <= 1'b0;
        res_enable <= 1'b0;
        @(negedge clk);
        check_flag("meas_valid", uut.meas_valid, enable);
        if (enable) begin
            resp   = offset_t'(t_rs - cmd_time);
            packet = offset_t'(t_rf - t_rs);
            for (int n = 0; n < MAX_SLAVES; n++) begin
                delay    = resp - slave_delay[n];
                measured = delay + (packet << 1);
                if (model_loaded) begin
                    model_acc[n] = model_acc[n] - (model_acc[n] >> LPF_GAIN)
                                 + {9'd0, measured};
                end else begin
                    model_acc[n] = {9'd0, measured} << LPF_GAIN;
                end
            end
            model_loaded = 1'b1;
        end
        repeat (6) @(posedge clk);  // three filter stages plus slack
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_after_reset();
        @(negedge clk);
        check_flag("cmd_valid", cmd_valid, 1'b0);
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            check_time("current_time", current_time, model_time());
        end
    endtask

    task automatic test_load_time();
        time_t value;
        value = time_t'(draw_bits(64));
        @(posedge clk);
        set_time  <= value;
        set_valid <= 1'b1;
        @(posedge clk);
        set_valid <= 1'b0;
        for (int k = 0; k < 12; k++) begin
            @(negedge clk);
            check_time("current_time", current_time, model_time());
        end
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, test did not finish", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        errors            = 0;
        cycle_count       = 0;
        lfsr_state        = 32'd77665;
        model_loaded      = 1'b0;
        set_time          = '0;
        set_valid         = 1'b0;
        cmd_start         = 1'b0;
        cmd_enable        = 1'b0;
        cmd_ready         = 1'b0;
        res_start         = 1'b0;
        res_finish        = 1'b0;
        res_enable        = 1'b0;
        res_payload_setup = 1'b0;
        res_data          = '0;
        res_valid         = 1'b0;
        for (int n = 0; n < MAX_SLAVES; n++) begin
            model_acc[n] = '0;
        end
        wait (reset === 1'b0);
        @(posedge clk);

        test_after_reset();
        test_load_time();
        collect_command(1'b0);        // before any response
        check_command(cmd_nop);
        run_round(1'b1);              // first round loads the filters
        collect_command(1'b0);
        check_command(cmd_correct_renew);
        run_round(1'b1);              // low-pass update
        collect_command(1'b1);
        check_command(cmd_correct);
        run_round(1'b0);              // ignored, res_enable low
        collect_command(1'b0);
        check_command(cmd_correct);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/synctimer_pkg.sv
verilog/synctimer_timer.sv
verilog/synctimer_response_rx.sv
verilog/synctimer_offset_filter.sv
verilog/synctimer_cmd_tx.sv
verilog/synctimer_master.sv
verification/tb_clock_gen.sv
verification/synctimer_asserts.sv
verification/synctimer_tb.sv

//--- Makefile
SOURCES := $(wildcard verilog/*.sv verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vsynctimer_tb: $(SOURCES) filelist.f
	verilator --binary --timing --assert -j 0 -f filelist.f \
		--top-module synctimer_tb -o Vsynctimer_tb

run: obj_dir/Vsynctimer_tb
	@out="$$(./obj_dir/Vsynctimer_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
